// ==== Makefile ====
# Verilator build and run of the I2C master testbench
TOP := tb_i2c_master
LOG := sim.log

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing -j 0 --top-module $(TOP) -f all.f -o sim
	./obj_dir/sim | tee $(LOG)
	grep -qF "*** PASSED ***" $(LOG)

lint:
	verilator --lint-only --timing --top-module $(TOP) -f all.f

clean:
	rm -rf obj_dir $(LOG)

// ==== all.f ====
hdl/i2c_pkg.sv
hdl/i2c_phase_gen.sv
hdl/i2c_byte_shift.sv
hdl/i2c_txn_ctrl.sv
hdl/i2c_master_top.sv
verification/i2c_slave_model.sv
verification/i2c_master_chk.sv
verification/tb_i2c_master.sv

// ==== hdl/i2c_byte_shift.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// one byte of bus data, MSB first in both directions
// load wins over shift when both strobes come together
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module i2c_byte_shift
    import i2c_pkg::*;
(
    input  logic              clk,
    input  logic              end_flag,
    input  logic              load,
    input  logic [BYTE_W-1:0] load_byte,
    input  logic              shift,
    input  logic              rx_bit,
    output logic              tx_bit,
    output logic              last_bit,
    output logic [BYTE_W-1:0] rx_byte
);

    logic [BYTE_W-1:0]    sr;
    logic [BIT_IDX_W-1:0] idx;

    // bit pointer
    always_ff @(posedge clk or posedge end_flag) begin
        if (end_flag) begin
            idx <= BIT_IDX_W'(BYTE_W - 1);
        end else if (load) begin
            idx <= BIT_IDX_W'(BYTE_W - 1);      // restart at the MSB
        end else if (shift) begin
            idx <= idx - BIT_IDX_W'(1);         // wraps to 7 after bit 0
        end
    end

    // data bits
    always_ff @(posedge clk) begin
        if (load) begin
            sr <= load_byte;
        end else if (shift) begin
            sr[idx] <= rx_bit;      // sent bit is done, keep what the bus saw
        end
    end

    assign tx_bit   = sr[idx];
    assign last_bit = (idx == '0);
    assign rx_byte  = sr;

endmodule

// ==== hdl/i2c_master_top.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// I2C master for single register access
// open-drain pad lives outside: line = sda_oe ? sda_o : pulled up
// sda_i must come through a synchronizer at the pad
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module i2c_master_top
    import i2c_pkg::*;
(
    input  logic              clk,
    input  logic              end_flag,
    input  logic              run_req,
    input  i2c_req_t          req,
    input  logic              sda_i,
    output logic              scl,
    output logic              sda_o,
    output logic              sda_oe,
    output logic [BYTE_W-1:0] rdata,
    output logic              done,
    output logic              ack_error
);

    sym_e              sym;
    logic              sym_end;
    logic              rx_bit;
    logic              load;
    logic              shift;
    logic              tx_bit;
    logic              last_bit;
    logic [BYTE_W-1:0] load_byte;
    logic [BYTE_W-1:0] rx_byte;

    i2c_txn_ctrl u_txn_ctrl (
        .clk       (clk),
        .end_flag  (end_flag),
        .run_req   (run_req),
        .req       (req),
        .sym_end   (sym_end),
        .rx_bit    (rx_bit),
        .last_bit  (last_bit),
        .rx_byte   (rx_byte),
        .sym       (sym),
        .load      (load),
        .load_byte (load_byte),
        .shift     (shift),
        .rdata     (rdata),
        .done      (done),
        .ack_error (ack_error)
    );

    i2c_phase_gen u_phase_gen (
        .clk      (clk),
        .end_flag (end_flag),
        .sym      (sym),
        .tx_bit   (tx_bit),
        .sda_i    (sda_i),
        .scl      (scl),
        .sda_o    (sda_o),
        .sda_oe   (sda_oe),
        .rx_bit   (rx_bit),
        .sym_end  (sym_end)
    );

    i2c_byte_shift u_byte_shift (
        .clk       (clk),
        .end_flag  (end_flag),
        .load      (load),
        .load_byte (load_byte),
        .shift     (shift),
        .rx_bit    (rx_bit),
        .tx_bit    (tx_bit),
        .last_bit  (last_bit),
        .rx_byte   (rx_byte)
    );

endmodule

// ==== hdl/i2c_phase_gen.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bus symbol timing, four clock cycles per symbol
// scl/sda pins are registered, so the bus lags the quarter count
// by one cycle; SCL rate is clk/4, no clock stretching
// sda_i must already be synchronized to clk
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module i2c_phase_gen
    import i2c_pkg::*;
(
    input  logic clk,
    input  logic end_flag,
    input  sym_e sym,
    input  logic tx_bit,
    input  logic sda_i,
    output logic scl,
    output logic sda_o,
    output logic sda_oe,
    output logic rx_bit,
    output logic sym_end
);

    quarter_e q;
    logic     sym_act;
    logic     scl_nxt;
    logic     sda_nxt;
    logic     oe_nxt;

    assign sym_act = (sym != SYM_IDLE);
    assign sym_end = sym_act && (q == Q_D);

    always_ff @(posedge clk or posedge end_flag) begin
        if (end_flag) begin
            q <= Q_A;
        end else if (!sym_act) begin
            q <= Q_A;               // park between transfers
        end else begin
            case (q)
                Q_A:     q <= Q_B;
                Q_B:     q <= Q_C;
                Q_C:     q <= Q_D;
                default: q <= Q_A;
            endcase
        end
    end

    // pin levels for the current quarter
    always_comb begin
        scl_nxt = 1'b1;
        sda_nxt = 1'b1;
        oe_nxt  = 1'b1;
        case (sym)
            SYM_START: begin
                scl_nxt = (q != Q_D);
                sda_nxt = (q == Q_A) || (q == Q_B);     // falls with scl high
            end
            SYM_RSTART: begin
                scl_nxt = (q == Q_B) || (q == Q_C);
                sda_nxt = (q == Q_A) || (q == Q_B);
            end
            SYM_STOP: begin
                scl_nxt = (q != Q_A);
                sda_nxt = (q == Q_C) || (q == Q_D);     // rises with scl high
            end
            SYM_TX_BIT: begin
                scl_nxt = (q == Q_B) || (q == Q_C);
                sda_nxt = tx_bit;                       // stable all four quarters
            end
            SYM_RX_BIT, SYM_ACK_IN: begin
                scl_nxt = (q == Q_B) || (q == Q_C);
                oe_nxt  = 1'b0;                         // slave owns sda
            end
            default: begin
                scl_nxt = 1'b1;
                sda_nxt = 1'b1;
            end
        endcase
    end

    always_ff @(posedge clk or posedge end_flag) begin
        if (end_flag) begin
            scl    <= 1'b1;
            sda_o  <= 1'b1;
            sda_oe <= 1'b1;
            rx_bit <= 1'b1;
        end else begin
            scl    <= scl_nxt;
            sda_o  <= sda_nxt;
            sda_oe <= oe_nxt;
            if (sym_act && ((q == Q_B) || (q == Q_C))) begin
                rx_bit <= sda_i;    // sample in C wins, scl high on the bus
            end
        end
    end

endmodule

// ==== hdl/i2c_pkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// common types of the I2C register-access master
// 7-bit slave addressing only, every payload is a single byte
// sym_e values are ordered by the sequencer and decoded by the
// phase generator, so keep both in step when adding a symbol
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package i2c_pkg;

    localparam int ADDR_W    = 7;   // slave address
    localparam int BYTE_W    = 8;
    localparam int BIT_IDX_W = 3;   // bit position inside a byte

    localparam logic DIR_WRITE = 1'b0;  // r/w bit after the address
    localparam logic DIR_READ  = 1'b1;

    // four quarters of one bus symbol
    typedef enum logic [1:0] {
        Q_A = 2'd0,
        Q_B = 2'd1,
        Q_C = 2'd2,
        Q_D = 2'd3
    } quarter_e;

    // bus symbols, master nack goes out as SYM_TX_BIT with a 1
    typedef enum logic [2:0] {
        SYM_IDLE   = 3'd0,
        SYM_START  = 3'd1,
        SYM_RSTART = 3'd2,
        SYM_STOP   = 3'd3,
        SYM_TX_BIT = 3'd4,
        SYM_RX_BIT = 3'd5,
        SYM_ACK_IN = 3'd6
    } sym_e;

    typedef enum logic [3:0] {
        ST_IDLE     = 4'd0,
        ST_START    = 4'd1,
        ST_ADDR_W   = 4'd2,
        ST_REG_ADDR = 4'd3,
        ST_WDATA    = 4'd4,
        ST_RSTART   = 4'd5,
        ST_ADDR_R   = 4'd6,
        ST_RDATA    = 4'd7,
        ST_ACK      = 4'd8,
        ST_NACK     = 4'd9,
        ST_STOP     = 4'd10
    } txn_state_e;

    // one register access
    typedef struct packed {
        logic [ADDR_W-1:0] slave_addr;
        logic              rd;          // 1 = register read
        logic [BYTE_W-1:0] wdata;       // ignored on reads
        logic [BYTE_W-1:0] reg_addr;
    } i2c_req_t;

endpackage

// ==== hdl/i2c_txn_ctrl.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// transfer sequencer for single register writes and reads
// req is sampled while idle, a run_req held high chains transfers
// a missing ack ends the transfer with stop and ack_error
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module i2c_txn_ctrl
    import i2c_pkg::*;
(
    input  logic              clk,
    input  logic              end_flag,
    input  logic              run_req,
    input  i2c_req_t          req,
    input  logic              sym_end,
    input  logic              rx_bit,
    input  logic              last_bit,
    input  logic [BYTE_W-1:0] rx_byte,
    output sym_e              sym,
    output logic              load,
    output logic [BYTE_W-1:0] load_byte,
    output logic              shift,
    output logic [BYTE_W-1:0] rdata,
    output logic              done,
    output logic              ack_error
);

    txn_state_e state;
    txn_state_e state_nxt;
    i2c_req_t   req_q;
    logic [1:0] byte_cnt;       // bytes acked so far in this transfer
    logic [1:0] stop_cnt;       // cycles spent in stop
    logic       ack_seen;
    logic       rx_done;

    assign ack_seen = (state == ST_ACK) && sym_end;
    assign rx_done  = (state == ST_RDATA) && sym_end && last_bit;

    always_comb begin
        case (state)
            ST_IDLE:   sym = SYM_IDLE;
            ST_START:  sym = SYM_START;
            ST_RSTART: sym = SYM_RSTART;
            ST_STOP:   sym = SYM_STOP;
            ST_RDATA:  sym = SYM_RX_BIT;
            ST_ACK:    sym = SYM_ACK_IN;
            default:   sym = SYM_TX_BIT;    // byte states and master nack
        endcase
    end

    always_comb begin
        state_nxt = state;
        load      = 1'b0;
        load_byte = {BYTE_W{1'b1}};     // released line, for read and nack
        shift     = 1'b0;
        case (state)
            ST_IDLE: begin
                if (run_req) state_nxt = ST_START;
            end
            ST_START: begin
                if (sym_end) begin
                    load      = 1'b1;
                    load_byte = {req_q.slave_addr, DIR_WRITE};
                    state_nxt = ST_ADDR_W;
                end
            end
            ST_ADDR_W, ST_REG_ADDR, ST_WDATA, ST_ADDR_R: begin
                if (sym_end) begin
                    shift = 1'b1;
                    if (last_bit) state_nxt = ST_ACK;
                end
            end
            ST_ACK: begin
                if (sym_end) begin
                    if (rx_bit) begin
                        state_nxt = ST_STOP;        // no ack, give up
                    end else begin
                        case (byte_cnt)
                            2'd0: begin             // after address + W
                                load      = 1'b1;
                                load_byte = req_q.reg_addr;
                                state_nxt = ST_REG_ADDR;
                            end
                            2'd1: begin             // after register address
                                if (req_q.rd) begin
                                    state_nxt = ST_RSTART;
                                end else begin
                                    load      = 1'b1;
                                    load_byte = req_q.wdata;
                                    state_nxt = ST_WDATA;
                                end
                            end
                            default: begin          // after wdata or address + R
                                if (req_q.rd) begin
                                    load      = 1'b1;
                                    state_nxt = ST_RDATA;
                                end else begin
                                    state_nxt = ST_STOP;
                                end
                            end
                        endcase
                    end
                end
            end
            ST_RSTART: begin
                if (sym_end) begin
                    load      = 1'b1;
                    load_byte = {req_q.slave_addr, DIR_READ};
                    state_nxt = ST_ADDR_R;
                end
            end
            ST_RDATA: begin
                if (sym_end) begin
                    shift = 1'b1;
                    if (last_bit) begin
                        load      = 1'b1;           // all ones, nack bit
                        state_nxt = ST_NACK;
                    end
                end
            end
            ST_NACK: begin
                if (sym_end) state_nxt = ST_STOP;
            end
            ST_STOP: begin
                if (sym_end) state_nxt = ST_IDLE;
            end
            default: state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge end_flag) begin
        if (end_flag) begin
            state     <= ST_IDLE;
            byte_cnt  <= 2'd0;
            stop_cnt  <= 2'd0;
            done      <= 1'b0;
            ack_error <= 1'b0;
        end else begin
            state    <= state_nxt;
            stop_cnt <= (state == ST_STOP) ? stop_cnt + 2'd1 : 2'd0;
            done     <= (state == ST_STOP) && (stop_cnt == 2'd1);  // lands in quarter C
            if (state == ST_IDLE) begin
                byte_cnt <= 2'd0;
                if (run_req) ack_error <= 1'b0;
            end else if (ack_seen && !rx_bit) begin
                byte_cnt <= byte_cnt + 2'd1;
            end
            if (ack_seen && rx_bit) ack_error <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE) req_q <= req;
        if (rx_done) rdata <= {rx_byte[BYTE_W-1:1], rx_bit};   // bit 0 not shifted in yet
    end

endmodule

// ==== verification/i2c_master_chk.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// port-level assertions for the I2C master, bound to the top level
// pulse checks are off while end_flag is high
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module i2c_master_chk (
    input logic clk,
    input logic end_flag,
    input logic scl,
    input logic sda_o,
    input logic sda_oe,
    input logic done
);

    a_done_one_cycle: assert property (
        @(posedge clk) disable iff (end_flag) done |=> !done
    ) else $error("done held longer than one cycle");

    a_oe_at_done: assert property (
        @(posedge clk) disable iff (end_flag) done |-> sda_oe
    ) else $error("sda_oe low while done is high");

    // bus idle right after reset release
    a_idle_after_reset: assert property (
        @(posedge clk) $fell(end_flag) |-> (scl && sda_o)
    ) else $error("bus not idle after reset release");

endmodule

bind i2c_master_top i2c_master_chk u_chk (
    .clk      (clk),
    .end_flag (end_flag),
    .scl      (scl),
    .sda_o    (sda_o),
    .sda_oe   (sda_oe),
    .done     (done)
);

// ==== verification/i2c_slave_model.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// behavioral open-drain I2C slave for the register master testbench
// samples the bus on the falling clk edge, so SCL must be slow vs clk
// one register byte per frame, records are cleared on each new start
// starts keeps counting across frames
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module i2c_slave_model
    import i2c_pkg::*;
(
    input  logic              clk,
    input  logic              scl,
    input  logic              sda_o,
    input  logic              sda_oe,
    input  logic [BYTE_W-1:0] read_byte,
    input  logic              ack_en,
    output logic              sda,          // resolved bus line
    output logic [BYTE_W-1:0] addr_w,
    output logic [BYTE_W-1:0] addr_r,
    output logic [BYTE_W-1:0] reg_addr,
    output logic [BYTE_W-1:0] wdata,
    output logic              reg_seen,
    output logic              nack_bit,     // master bit on the ninth read clock
    output logic [7:0]        starts,
    output logic [7:0]        rstarts,
    output logic [7:0]        stops
);

    logic              pull;
    logic              scl_q;
    logic              sda_q;
    logic              in_frame;
    logic              tx_mode;
    logic              go_tx;
    logic [3:0]        bit_cnt;
    logic [1:0]        byte_idx;
    logic [BYTE_W-1:0] sh;
    logic [BYTE_W-1:0] tx_sh;

    // wired-AND of both drivers
    assign sda = (sda_oe ? sda_o : 1'b1) & ~pull;

    initial begin
        pull     = 1'b0;
        scl_q    = 1'b1;
        sda_q    = 1'b1;
        in_frame = 1'b0;
        tx_mode  = 1'b0;
        go_tx    = 1'b0;
        bit_cnt  = 4'd0;
        byte_idx = 2'd0;
        sh       = '0;
        tx_sh    = '0;
        addr_w   = '0;
        addr_r   = '0;
        reg_addr = '0;
        wdata    = '0;
        reg_seen = 1'b0;
        nack_bit = 1'b0;
        starts   = 8'd0;
        rstarts  = 8'd0;
        stops    = 8'd0;
    end

    always @(negedge clk) begin
        logic s;
        s = sda;
        if (scl && scl_q && sda_q && !s) begin          // start or repeated start
            if (in_frame) begin
                rstarts = rstarts + 8'd1;
            end else begin
                starts   = starts + 8'd1;
                rstarts  = 8'd0;
                stops    = 8'd0;
                reg_seen = 1'b0;
                nack_bit = 1'b0;
                addr_w   = '0;
                addr_r   = '0;
                reg_addr = '0;
                wdata    = '0;
            end
            in_frame = 1'b1;
            tx_mode  = 1'b0;
            go_tx    = 1'b0;
            bit_cnt  = 4'd0;
            byte_idx = 2'd0;
            pull     = 1'b0;
        end else if (scl && scl_q && !sda_q && s) begin // stop
            in_frame = 1'b0;
            tx_mode  = 1'b0;
            pull     = 1'b0;
            stops    = stops + 8'd1;
        end else if (scl && !scl_q) begin               // rising SCL
            if (bit_cnt < 4'd8) begin
                if (!tx_mode) sh = {sh[BYTE_W-2:0], s};
            end else if (tx_mode) begin
                nack_bit = s;
            end
            bit_cnt = bit_cnt + 4'd1;
        end else if (!scl && scl_q) begin               // falling SCL
            if (tx_mode) begin
                if (bit_cnt < 4'd8) begin
                    tx_sh = {tx_sh[BYTE_W-2:0], 1'b1};
                    pull  = !tx_sh[BYTE_W-1];
                end else if (bit_cnt == 4'd8) begin
                    pull = 1'b0;                        // master answers
                end else begin
                    pull    = 1'b0;
                    tx_mode = 1'b0;
                    bit_cnt = 4'd0;
                end
            end else if (bit_cnt == 4'd8) begin
                case (byte_idx)
                    2'd0: begin
                        if (sh[0]) addr_r = sh;
                        else addr_w = sh;
                        go_tx = sh[0] && ack_en;
                    end
                    2'd1: begin
                        reg_addr = sh;
                        reg_seen = 1'b1;
                    end
                    default: wdata = sh;
                endcase
                byte_idx = byte_idx + 2'd1;
                pull     = ack_en;
            end else if (bit_cnt == 4'd9) begin
                pull    = 1'b0;
                bit_cnt = 4'd0;
                if (go_tx) begin                        // read data follows
                    go_tx   = 1'b0;
                    tx_mode = 1'b1;
                    tx_sh   = read_byte;
                    pull    = !read_byte[BYTE_W-1];
                end
            end
        end
        scl_q = scl;
        sda_q = s;
    end

endmodule

// ==== verification/i2c_testdata.txt ====
// kind rd addr reg wdata slave_rbyte slave_ack exp_rdata exp_ack_error (hex)
// kind 0 single, 1 run_req held with next line's request swapped in, 2 follow-up
00 00 50 12 A5 00 01 00 00
00 01 3C 07 00 96 01 96 00
00 01 7F FF 00 5A 01 5A 00
00 00 21 44 11 00 00 00 01
00 01 62 08 00 77 00 00 01
01 00 2A 10 C3 00 01 00 00
02 01 55 20 00 3E 01 3E 00
00 00 01 80 0F 00 01 00 00

// ==== verification/tb_i2c_master.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the I2C register master
// tests come from verification/i2c_testdata.txt, run from project root
// kind 1 keeps run_req high and swaps in the next line's request,
// which must then be a kind 2 line
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_i2c_master
    import i2c_pkg::*;
();

    localparam int N_FIELDS  = 9;
    localparam int MAX_TESTS = 16;

    logic              clk;
    logic              end_flag;
    logic              run_req;
    i2c_req_t          req;
    logic              sda_line;
    logic              scl;
    logic              sda_o;
    logic              sda_oe;
    logic [BYTE_W-1:0] rdata;
    logic              done;
    logic              ack_error;
    logic [BYTE_W-1:0] read_byte;
    logic              ack_en;
    logic [BYTE_W-1:0] addr_w;
    logic [BYTE_W-1:0] addr_r;
    logic [BYTE_W-1:0] reg_addr;
    logic [BYTE_W-1:0] wdata;
    logic              reg_seen;
    logic              nack_bit;
    logic [7:0]        starts;
    logic [7:0]        rstarts;
    logic [7:0]        stops;

    logic [7:0] tdata [0:MAX_TESTS*N_FIELDS-1];
    int         n_tests;
    int         err_cnt;
    int         test_err;
    int         fail_tests;
    int         cycles;
    int         limit;

    i2c_master_top u_i2c_master_top (
        .clk       (clk),
        .end_flag  (end_flag),
        .run_req   (run_req),
        .req       (req),
        .sda_i     (sda_line),
        .scl       (scl),
        .sda_o     (sda_o),
        .sda_oe    (sda_oe),
        .rdata     (rdata),
        .done      (done),
        .ack_error (ack_error)
    );

    i2c_slave_model u_slave (
        .clk       (clk),
        .scl       (scl),
        .sda_o     (sda_o),
        .sda_oe    (sda_oe),
        .read_byte (read_byte),
        .ack_en    (ack_en),
        .sda       (sda_line),
        .addr_w    (addr_w),
        .addr_r    (addr_r),
        .reg_addr  (reg_addr),
        .wdata     (wdata),
        .reg_seen  (reg_seen),
        .nack_bit  (nack_bit),
        .starts    (starts),
        .rstarts   (rstarts),
        .stops     (stops)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // run limit, armed once the test count is known
    initial begin
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (limit > 0 && cycles >= limit) begin
                $display("timeout: no done after %0d cycles", cycles);
                $display("*** FAILED ***");
                $finish;
            end
        end
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL %s: got 0x%0h expected 0x%0h", name, got, exp);
            err_cnt++;
            test_err++;
        end
    endtask

    function automatic i2c_req_t line_req(input int i);
        i2c_req_t r;
        int       b;
        b            = i * N_FIELDS;
        r.slave_addr = tdata[b+2][ADDR_W-1:0];
        r.rd         = tdata[b+1][0];
        r.wdata      = tdata[b+4];
        r.reg_addr   = tdata[b+3];
        return r;
    endfunction

    task automatic wait_done();
        while (!done) @(negedge clk);
    endtask

    task automatic run_line(input int i);
        int                b;
        logic [7:0]        kind;
        logic              rd;
        logic              exp_err;
        logic [ADDR_W-1:0] addr;
        logic [7:0]        start_base;
        logic [7:0]        new_starts;
        b        = i * N_FIELDS;
        kind     = tdata[b];
        rd       = tdata[b+1][0];
        addr     = tdata[b+2][ADDR_W-1:0];
        exp_err  = tdata[b+8][0];
        test_err = 0;
        start_base = starts;            // slave keeps a running count
        read_byte = tdata[b+5];
        ack_en    = tdata[b+6][0];
        if (kind == 8'd2) begin
            @(posedge clk);     // second frame starts on this edge
            #2 run_req = 1'b0;
        end else begin
            @(posedge clk);
            #2;
            req     = line_req(i);
            run_req = 1'b1;
            @(posedge clk);
            #2;
            if (kind == 8'd1) begin
                repeat (40) @(posedge clk);
                #2 req = line_req(i + 1);   // lands mid-frame
            end else begin
                run_req = 1'b0;
            end
        end
        wait_done();
        check("ack_error", 32'(ack_error), 32'(exp_err));
        repeat (2) @(negedge clk);      // let the stop reach the slave
        new_starts = starts - start_base;
        check("starts", 32'(new_starts), 32'd1);
        check("stops", 32'(stops), 32'd1);
        check("addr_w", 32'(addr_w), 32'({addr, DIR_WRITE}));
        if (exp_err) begin
            check("reg_seen", 32'(reg_seen), 32'd0);
        end else begin
            check("reg_addr", 32'(reg_addr), 32'(tdata[b+3]));
            if (rd) begin
                check("rstarts", 32'(rstarts), 32'd1);
                check("addr_r", 32'(addr_r), 32'({addr, DIR_READ}));
                check("rdata", 32'(rdata), 32'(tdata[b+7]));
                check("nack_bit", 32'(nack_bit), 32'd1);
            end else begin
                check("rstarts", 32'(rstarts), 32'd0);
                check("wdata", 32'(wdata), 32'(tdata[b+4]));
            end
        end
        if (test_err != 0) fail_tests++;
        $display("test %0d kind %0d rd %0d: %s", i + 1, kind, rd,
                 (test_err == 0) ? "ok" : "mismatch");
    endtask

    initial begin
        end_flag   = 1'b1;
        run_req    = 1'b0;
        req        = '0;
        read_byte  = '0;
        ack_en     = 1'b1;
        err_cnt    = 0;
        test_err   = 0;
        fail_tests = 0;
        limit      = 0;
        n_tests    = 0;
        for (int k = 0; k < MAX_TESTS * N_FIELDS; k++) tdata[k] = 8'hff;
        $readmemh("verification/i2c_testdata.txt", tdata);
        while (n_tests < MAX_TESTS && tdata[n_tests*N_FIELDS] != 8'hff) n_tests++;
        limit = n_tests * 39 * 4 + n_tests * 60 + 200;

        // reset values, during and just after end_flag
        @(negedge clk);
        check("scl", 32'(scl), 32'd1);
        check("sda_o", 32'(sda_o), 32'd1);
        check("done", 32'(done), 32'd0);
        check("ack_error", 32'(ack_error), 32'd0);
        repeat (5) @(posedge clk);
        #2 end_flag = 1'b0;
        @(negedge clk);
        check("scl", 32'(scl), 32'd1);
        check("sda_o", 32'(sda_o), 32'd1);
        check("done", 32'(done), 32'd0);
        check("ack_error", 32'(ack_error), 32'd0);
        if (test_err != 0) fail_tests++;
        $display("test 0 reset: %s", (test_err == 0) ? "ok" : "mismatch");

        for (int i = 0; i < n_tests; i++) run_line(i);

        $display("summary: %0d tests, %0d failed, %0d mismatches",
                 n_tests + 1, fail_tests, err_cnt);
        if (err_cnt == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule
